//--- rtl/mipsPkg.sv
`default_nettype none

package mipsPkg;

   // Widths with a meaning of their own
   typedef logic [31:0] wordT;
   typedef logic [31:0] addrT;
   typedef logic [4:0]  regAddrT;
   typedef logic [31:0] instrT;

   // Primary opcode field, kept subset only
   typedef enum logic [5:0] {
      opSpecial = 6'h00,
      opJ       = 6'h02,
      opJal     = 6'h03,
      opBeq     = 6'h04,
      opBne     = 6'h05,
      opAddiu   = 6'h09,
      opSlti    = 6'h0a,
      opAndi    = 6'h0c,
      opOri     = 6'h0d,
      opXori    = 6'h0e,
      opLui     = 6'h0f
   } opcodeE;

   // Function field of special instructions
   typedef enum logic [5:0] {
      fnSll  = 6'h00,
      fnSrl  = 6'h02,
      fnSra  = 6'h03,
      fnJr   = 6'h08,
      fnAddu = 6'h21,
      fnSubu = 6'h23,
      fnAnd  = 6'h24,
      fnOr   = 6'h25,
      fnXor  = 6'h26,
      fnNor  = 6'h27,
      fnSlt  = 6'h2a,
      fnSltu = 6'h2b
   } functE;

   typedef enum logic [3:0] {
      aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
      aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
   } aluOpE;

   // First fetch address after reset
   localparam addrT resetPc = 32'h4000_0000;

   // JAL return address goes here
   localparam regAddrT linkReg = 5'd31;
   // Return address skips the delay slot
   localparam wordT linkOffset = 32'd8;

endpackage

`default_nettype wire

//--- rtl/instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecode import mipsPkg::*; (
   input  instrT       instruction,
   output regAddrT     rs,
   output regAddrT     rt,
   output regAddrT     rd,
   output regAddrT     shamt,
   output opcodeE      opcode,
   output aluOpE       aluOp,
   output wordT        immExt,
   output logic [25:0] target,
   output logic        regWrite,
   output logic        aluSrc,
   output logic        shiftSel,
   output logic        regDst,
   output logic        link,
   output logic        branchEq,
   output logic        branchNe,
   output logic        jump,
   output logic        jumpReg
);
   functE   funct;
   logic    signExt;
   logic    writeReq;
   regAddrT dest;

   // Raw fields
   assign opcode = opcodeE'(instruction[31:26]);
   assign funct  = functE'(instruction[5:0]);
   assign rs     = instruction[25:21];
   assign rt     = instruction[20:16];
   assign rd     = instruction[15:11];
   assign shamt  = instruction[10:6];
   assign target = instruction[25:0];

   // Arithmetic and branches sign-extend, logic ops zero-extend
   assign immExt = signExt ? {{16{instruction[15]}}, instruction[15:0]}
                           : {16'h0000, instruction[15:0]};

   // Write to r0 turns into a no-op, JAL always targets r31
   assign dest     = regDst ? rd : rt;
   assign regWrite = writeReq && (link || (dest != '0));

   always_comb begin
      aluOp    = aluAdd;
      writeReq = 1'b0;
      aluSrc   = 1'b0;
      shiftSel = 1'b0;
      regDst   = 1'b0;
      link     = 1'b0;
      branchEq = 1'b0;
      branchNe = 1'b0;
      jump     = 1'b0;
      jumpReg  = 1'b0;
      signExt  = 1'b0;
      case (opcode)
         opSpecial: begin
            regDst   = 1'b1;
            writeReq = 1'b1;
            case (funct)
               fnAddu: aluOp = aluAdd;
               fnSubu: aluOp = aluSub;
               fnAnd:  aluOp = aluAnd;
               fnOr:   aluOp = aluOr;
               fnXor:  aluOp = aluXor;
               fnNor:  aluOp = aluNor;
               fnSlt:  aluOp = aluSlt;
               fnSltu: aluOp = aluSltu;
               fnSll, fnSrl, fnSra: begin
                  // Amount comes from shamt, value from rt
                  shiftSel = 1'b1;
                  aluOp    = (funct == fnSll) ? aluSll :
                             (funct == fnSrl) ? aluSrl : aluSra;
               end
               fnJr: begin
                  writeReq = 1'b0;
                  jumpReg  = 1'b1;
               end
               default: writeReq = 1'b0;
            endcase
         end
         opJ: jump = 1'b1;
         opJal: begin
            jump     = 1'b1;
            link     = 1'b1;
            writeReq = 1'b1;
         end
         opBeq, opBne: begin
            // Compare by subtraction, zero flag decides
            aluOp    = aluSub;
            branchEq = (opcode == opBeq);
            branchNe = (opcode == opBne);
            signExt  = 1'b1;
         end
         opAddiu, opSlti: begin
            aluOp    = (opcode == opSlti) ? aluSlt : aluAdd;
            aluSrc   = 1'b1;
            writeReq = 1'b1;
            signExt  = 1'b1;
         end
         opAndi, opOri, opXori, opLui: begin
            aluOp    = (opcode == opAndi) ? aluAnd :
                       (opcode == opOri)  ? aluOr  :
                       (opcode == opXori) ? aluXor : aluLui;
            aluSrc   = 1'b1;
            writeReq = 1'b1;
         end
         // Unknown opcode stays a no-op
         default: writeReq = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

//--- rtl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import mipsPkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  logic    writeEn,
   input  regAddrT readAddrA,
   input  regAddrT readAddrB,
   input  regAddrT writeAddr,
   input  wordT    writeData,
   output wordT    readDataA,
   output wordT    readDataB
);
   // r0 has no storage
   wordT regs [1:31];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn && (writeAddr != '0)) begin
         regs[writeAddr] <= writeData;
      end
   end

   // Asynchronous read, r0 pinned to zero
   assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
   assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

   // Decode must already have killed writes to r0
   noWriteToZero : assert property (
      @(posedge clk) disable iff (reset) writeEn |-> (writeAddr != '0)
   );

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import mipsPkg::*; (
   input  wordT  opA,
   input  wordT  opB,
   input  aluOpE aluOp,
   output wordT  result,
   output logic  zero
);
   logic [4:0] shiftAmt;

   // Shift amount from low bits of A, value shifted is B
   assign shiftAmt = opA[4:0];

   always_comb begin
      case (aluOp)
         aluAdd:  result = opA + opB;
         aluSub:  result = opA - opB;
         aluAnd:  result = opA & opB;
         aluOr:   result = opA | opB;
         aluXor:  result = opA ^ opB;
         aluNor:  result = ~(opA | opB);
         // Set-less-than, signed and unsigned
         aluSlt:  result = {31'b0, $signed(opA) < $signed(opB)};
         aluSltu: result = {31'b0, opA < opB};
         aluSll:  result = opB << shiftAmt;
         aluSrl:  result = opB >> shiftAmt;
         aluSra:  result = wordT'($signed(opB) >>> shiftAmt);
         // Immediate into upper half
         aluLui:  result = {opB[15:0], 16'h0000};
         default: result = '0;
      endcase
   end

   // Used with SUB for BEQ and BNE
   assign zero = (result == '0);

endmodule

`default_nettype wire

//--- rtl/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import mipsPkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        stall,
   input  logic        branchTaken,
   input  logic        jump,
   input  logic        jumpReg,
   input  wordT        branchOffset,
   input  logic [25:0] jumpTarget,
   input  wordT        regTarget,
   output addrT        pc
);
   addrT nextPc;

   // Redirect comes from execute while the delay slot sits in fetch,
   // so pc here is already branch address plus 4
   always_comb begin
      if (branchTaken) begin
         nextPc = pc + (branchOffset << 2);
      end else if (jump) begin
         // Region bits taken from the delay slot address
         nextPc = {pc[31:28], jumpTarget, 2'b00};
      end else if (jumpReg) begin
         nextPc = regTarget;
      end else begin
         nextPc = pc + 32'd4;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= resetPc;
      end else if (!stall) begin
         pc <= nextPc;
      end
   end

   // Only one instruction in execute, so one redirect kind at a time
   oneRedirect : assert property (
      @(posedge clk) disable iff (reset) $onehot0({branchTaken, jump, jumpReg})
   );

   pcAligned : assert property (
      @(posedge clk) disable iff (reset) pc[1:0] == 2'b00
   );

endmodule

`default_nettype wire

//--- rtl/pipeDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module pipeDatapath import mipsPkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  logic    stall,
   input  instrT   instruction,
   output addrT    instrAddr,
   output logic    wbValid,
   output regAddrT wbAddr,
   output wordT    wbData
);
   // Fetch/decode stage
   regAddrT     decRs;
   regAddrT     decRt;
   regAddrT     decRd;
   regAddrT     decShamt;
   aluOpE       decAluOp;
   wordT        decImm;
   logic [25:0] decTarget;
   logic        decRegWrite;
   logic        decAluSrc;
   logic        decShiftSel;
   logic        decRegDst;
   logic        decLink;
   logic        decBranchEq;
   logic        decBranchNe;
   logic        decJump;
   logic        decJumpReg;
   wordT        rfDataA;
   wordT        rfDataB;
   wordT        readA;
   wordT        readB;
   addrT        pc;

   // Execute stage
   logic        exRegWrite;
   logic        exAluSrc;
   logic        exShiftSel;
   logic        exRegDst;
   logic        exLink;
   logic        exBranchEq;
   logic        exBranchNe;
   logic        exJump;
   logic        exJumpReg;
   aluOpE       exAluOp;
   wordT        exDataA;
   wordT        exDataB;
   wordT        exImm;
   regAddrT     exRs;
   regAddrT     exRt;
   regAddrT     exRd;
   regAddrT     exShamt;
   logic [25:0] exTarget;
   addrT        exPc;
   wordT        fwdA;
   wordT        fwdB;
   wordT        opA;
   wordT        opB;
   wordT        aluResult;
   logic        aluZero;
   logic        branchTaken;

   // Memory/write-back stage
   logic        memRegWrite;
   logic        memLink;
   wordT        memResult;
   regAddrT     memDest;
   addrT        memPc;

   instrDecode decoder (
      .instruction (instruction),
      .rs          (decRs),
      .rt          (decRt),
      .rd          (decRd),
      .shamt       (decShamt),
      .opcode      (),
      .aluOp       (decAluOp),
      .immExt      (decImm),
      .target      (decTarget),
      .regWrite    (decRegWrite),
      .aluSrc      (decAluSrc),
      .shiftSel    (decShiftSel),
      .regDst      (decRegDst),
      .link        (decLink),
      .branchEq    (decBranchEq),
      .branchNe    (decBranchNe),
      .jump        (decJump),
      .jumpReg     (decJumpReg)
   );

   // Write port gated by stall through wbValid
   regFile registers (
      .clk       (clk),
      .reset     (reset),
      .writeEn   (wbValid),
      .readAddrA (decRs),
      .readAddrB (decRt),
      .writeAddr (wbAddr),
      .writeData (wbData),
      .readDataA (rfDataA),
      .readDataB (rfDataB)
   );

   fetchUnit fetch (
      .clk          (clk),
      .reset        (reset),
      .stall        (stall),
      .branchTaken  (branchTaken),
      .jump         (exJump),
      .jumpReg      (exJumpReg),
      .branchOffset (exImm),
      .jumpTarget   (exTarget),
      .regTarget    (fwdA),
      .pc           (pc)
   );

   assign instrAddr = pc;

   // Write-back bypass into register read, producer two ahead
   assign readA = (memRegWrite && (wbAddr == decRs)) ? wbData : rfDataA;
   assign readB = (memRegWrite && (wbAddr == decRt)) ? wbData : rfDataB;

   // Control cleared to no-op on reset
   always_ff @(posedge clk) begin
      if (reset) begin
         exRegWrite <= 1'b0;
         exAluSrc   <= 1'b0;
         exShiftSel <= 1'b0;
         exRegDst   <= 1'b0;
         exLink     <= 1'b0;
         exBranchEq <= 1'b0;
         exBranchNe <= 1'b0;
         exJump     <= 1'b0;
         exJumpReg  <= 1'b0;
         exAluOp    <= aluAdd;
      end else if (!stall) begin
         exRegWrite <= decRegWrite;
         exAluSrc   <= decAluSrc;
         exShiftSel <= decShiftSel;
         exRegDst   <= decRegDst;
         exLink     <= decLink;
         exBranchEq <= decBranchEq;
         exBranchNe <= decBranchNe;
         exJump     <= decJump;
         exJumpReg  <= decJumpReg;
         exAluOp    <= decAluOp;
      end
   end

   // Payload, no reset
   always_ff @(posedge clk) begin
      if (!stall) begin
         exDataA  <= readA;
         exDataB  <= readB;
         exImm    <= decImm;
         exRs     <= decRs;
         exRt     <= decRt;
         exRd     <= decRd;
         exShamt  <= decShamt;
         exTarget <= decTarget;
         exPc     <= pc;
      end
   end

   // Memory-stage bypass into execute, producer one ahead
   assign fwdA = (memRegWrite && (wbAddr == exRs)) ? wbData : exDataA;
   assign fwdB = (memRegWrite && (wbAddr == exRt)) ? wbData : exDataB;

   assign opA = exShiftSel ? {27'b0, exShamt} : fwdA;
   assign opB = exAluSrc ? exImm : fwdB;

   alu execUnit (
      .opA    (opA),
      .opB    (opB),
      .aluOp  (exAluOp),
      .result (aluResult),
      .zero   (aluZero)
   );

   assign branchTaken = (exBranchEq && aluZero) || (exBranchNe && !aluZero);

   always_ff @(posedge clk) begin
      if (reset) begin
         memRegWrite <= 1'b0;
         memLink     <= 1'b0;
      end else if (!stall) begin
         memRegWrite <= exRegWrite;
         memLink     <= exLink;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         memResult <= aluResult;
         memDest   <= exRegDst ? exRd : exRt;
         memPc     <= exPc;
      end
   end

   // JAL writes its return address to r31
   assign wbAddr  = memLink ? linkReg : memDest;
   assign wbData  = memLink ? (memPc + linkOffset) : memResult;
   assign wbValid = memRegWrite && !stall;

   // A write held by stall is reported later with the same address and data
   stallHoldsWrite : assert property (
      @(posedge clk) disable iff (reset)
         stall |-> !wbValid ##1 ($stable(wbAddr) && $stable(wbData))
   );

endmodule

`default_nettype wire

//--- testbench/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// LCG step, upper bits used since low bits repeat quickly
function automatic logic [31:0] randBelow(input int unsigned limit);
   seed = seed * 32'd1664525 + 32'd1013904223;
   return (seed >> 8) % limit;
endfunction

// Small pool keeps dependencies dense, slot 8 stands for r31
function automatic regAddrT pickReg();
   int r;
   r = randBelow(9);
   return (r == 8) ? linkReg : regAddrT'(r);
endfunction

function automatic instrT rType(functE fn, regAddrT rs, regAddrT rt, regAddrT rd,
                                regAddrT sa);
   return {opSpecial, rs, rt, rd, sa, fn};
endfunction

function automatic instrT iType(opcodeE op, regAddrT rs, regAddrT rt, logic [15:0] imm);
   return {op, rs, rt, imm};
endfunction

// Word index field of an absolute target
function automatic instrT jType(opcodeE op, addrT dest);
   return {op, dest[27:2]};
endfunction

// Kind 0..7 register ops, 8..10 shifts, 11..16 immediate ops
function automatic instrT randomAlu(input int kind);
   functE       fns [11] = '{fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu,
                             fnSll, fnSrl, fnSra};
   opcodeE      ops [6] = '{opAddiu, opSlti, opAndi, opOri, opXori, opLui};
   regAddrT     rs;
   regAddrT     rt;
   regAddrT     rd;
   logic [15:0] imm;
   instrT       result;
   rs = pickReg();
   rt = pickReg();
   rd = pickReg();
   imm = 16'(randBelow(65536));
   if (kind < 8) begin
      result = rType(fns[kind], rs, rt, rd, 5'd0);
   end else if (kind < 11) begin
      result = rType(fns[kind], 5'd0, rt, rd, imm[4:0]);
   end else begin
      result = iType(ops[kind - 11], rs, rt, imm);
   end
   return result;
endfunction

// Forward control only, target never a delay slot
function automatic void makeProgram(input bit withControl);
   int      i;
   int      j;
   int      t;
   int      kind;
   regAddrT jr;
   addrT    dest;
   i = 0;
   while (i < bodyLen) begin
      if (withControl && (i + 6 <= bodyLen) && (randBelow(4) == 0)) begin
         kind = randBelow(5);
         // Delay slot, then up to two skipped; JR needs two loads first
         t = i + 2 + randBelow(3) + ((kind == 4) ? 2 : 0);
         dest = resetPc + 4 * t;
         case (kind)
            0: imem[i] = iType(opBeq, pickReg(), pickReg(), 16'(t - i - 1));
            1: imem[i] = iType(opBne, pickReg(), pickReg(), 16'(t - i - 1));
            2: imem[i] = jType(opJ, dest);
            3: imem[i] = jType(opJal, dest);
            default: begin
               jr = regAddrT'(1 + randBelow(7));
               imem[i]     = iType(opLui, 5'd0, jr, dest[31:16]);
               imem[i + 1] = iType(opOri, jr, jr, dest[15:0]);
               imem[i + 2] = rType(fnJr, jr, 5'd0, 5'd0, 5'd0);
               i = i + 2;
            end
         endcase
         // Delay slot and skipped words are plain ALU ops
         for (j = i + 1; j < t; j++) begin
            imem[j] = randomAlu(randBelow(17));
         end
         i = t;
      end else begin
         imem[i] = randomAlu(withControl ? int'(randBelow(17)) : i % 17);
         i++;
      end
   end
   // Halt loop, jump to itself with a nop behind
   imem[bodyLen]     = jType(opJ, haltAddr);
   imem[bodyLen + 1] = '0;
endfunction

// Instruction-level execution with one delay slot
function automatic void runModel();
   wordT    regs [32];
   addrT    pc;
   addrT    npc;
   addrT    nextNpc;
   instrT   ins;
   opcodeE  op;
   functE   fn;
   regAddrT dest;
   wordT    a;
   wordT    b;
   wordT    value;
   wordT    sImm;
   logic    doWrite;
   int      steps;
   for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
   end
   expAddr.delete();
   expData.delete();
   pc = resetPc;
   npc = resetPc + 4;
   steps = 0;
   while ((pc != haltAddr) && (steps < 4 * progLen)) begin
      ins = imem[(pc - resetPc) >> 2];
      op = opcodeE'(ins[31:26]);
      fn = functE'(ins[5:0]);
      a = regs[ins[25:21]];
      b = regs[ins[20:16]];
      sImm = {{16{ins[15]}}, ins[15:0]};
      nextNpc = npc + 4;
      doWrite = 1'b1;
      dest = ins[20:16];
      value = '0;
      case (op)
         opSpecial: begin
            dest = ins[15:11];
            case (fn)
               fnAddu: value = a + b;
               fnSubu: value = a - b;
               fnAnd:  value = a & b;
               fnOr:   value = a | b;
               fnXor:  value = a ^ b;
               fnNor:  value = ~(a | b);
               fnSlt:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               fnSltu: value = (a < b) ? 32'd1 : 32'd0;
               fnSll:  value = b << ins[10:6];
               fnSrl:  value = b >> ins[10:6];
               fnSra:  value = $signed(b) >>> ins[10:6];
               fnJr: begin
                  doWrite = 1'b0;
                  nextNpc = a;
               end
               default: doWrite = 1'b0;
            endcase
         end
         opJ: begin
            doWrite = 1'b0;
            nextNpc = {npc[31:28], ins[25:0], 2'b00};
         end
         opJal: begin
            dest = linkReg;
            value = pc + 8;
            nextNpc = {npc[31:28], ins[25:0], 2'b00};
         end
         opBeq, opBne: begin
            doWrite = 1'b0;
            if ((a == b) == (op == opBeq)) begin
               nextNpc = npc + (sImm << 2);
            end
         end
         opAddiu: value = a + sImm;
         opSlti:  value = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
         opAndi:  value = a & {16'h0000, ins[15:0]};
         opOri:   value = a | {16'h0000, ins[15:0]};
         opXori:  value = a ^ {16'h0000, ins[15:0]};
         opLui:   value = {ins[15:0], 16'h0000};
         default: doWrite = 1'b0;
      endcase
      // r0 never changes and is never reported
      if (doWrite && (dest != '0)) begin
         regs[dest] = value;
         expAddr.push_back(dest);
         expData.push_back(value);
      end
      pc = npc;
      npc = nextNpc;
      steps++;
   end
endfunction

`endif

//--- testbench/datapathTb.sv
`timescale 1ns/1ps
`default_nettype none

module datapathTb import mipsPkg::*; ();
   localparam int bodyLen = 64;
   // Body plus halt jump and its nop
   localparam int progLen = bodyLen + 2;
   localparam int clkPeriod = 40;
   localparam int resetCycles = 8;
   localparam int numTests = 5;
   localparam addrT haltAddr = resetPc + 4 * bodyLen;

   logic    clk;
   logic    reset;
   logic    stall;
   instrT   instruction;
   addrT    instrAddr;
   logic    wbValid;
   regAddrT wbAddr;
   wordT    wbData;

   instrT       imem [progLen];
   regAddrT     expAddr [$];
   wordT        expData [$];
   logic [31:0] seed = 32'heb6c_19f1;
   int          writeIdx = 0;
   int          checked = 0;
   int          errors = 0;

   `include "isaModel.svh"

   pipeDatapath DUT (
      .clk         (clk),
      .reset       (reset),
      .stall       (stall),
      .instruction (instruction),
      .instrAddr   (instrAddr),
      .wbValid     (wbValid),
      .wbAddr      (wbAddr),
      .wbData      (wbData)
   );

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   // Same-cycle fetch with nop outside the program
   always_comb begin
      if ((instrAddr >= resetPc) && (instrAddr < resetPc + 4 * progLen)) begin
         instruction = imem[(instrAddr - resetPc) >> 2];
      end else begin
         instruction = '0;
      end
   end

   // One reported write against the next model entry
   task automatic checkWrite();
      assert (wbAddr != '0) else begin
         errors++;
         $display("Write to register zero reported at %0t", $time);
      end
      assert (writeIdx < expAddr.size()) else begin
         errors++;
         $display("Extra write to r%0d beyond the %0d expected", wbAddr, expAddr.size());
      end
      if (writeIdx < expAddr.size()) begin
         assert (wbAddr == expAddr[writeIdx]) else begin
            errors++;
            $display("MISMATCH wbAddr write %0d: got %h expected %h",
                     writeIdx, wbAddr, expAddr[writeIdx]);
         end
         assert (wbData == expData[writeIdx]) else begin
            errors++;
            $display("MISMATCH wbData write %0d: got %h expected %h",
                     writeIdx, wbData, expData[writeIdx]);
         end
      end
      writeIdx++;
      checked++;
   endtask

   // Sample mid-cycle once stall and outputs have settled
   always @(negedge clk) begin
      if (!reset && wbValid) begin
         checkWrite();
      end
   end

   task automatic runTest(input bit withControl, input int stallPct);
      int drained;
      @(posedge clk);
      #2;
      reset = 1'b1;
      stall = 1'b0;
      makeProgram(withControl);
      runModel();
      writeIdx = 0;
      repeat (resetCycles) @(posedge clk);
      #2;
      reset = 1'b0;
      @(negedge clk);
      assert (instrAddr == resetPc) else begin
         errors++;
         $display("MISMATCH instrAddr: got %h expected %h", instrAddr, resetPc);
      end
      // Run until fetch enters the halt loop
      while (instrAddr != haltAddr) begin
         @(posedge clk);
         #2;
         stall = (randBelow(100) < stallPct);
         @(negedge clk);
      end
      // Up to two older instructions still in flight
      drained = 0;
      while (drained < 4) begin
         @(posedge clk);
         if (!stall) begin
            drained++;
         end
         #2;
         stall = (randBelow(100) < stallPct);
      end
      stall = 1'b0;
      assert (writeIdx == expAddr.size()) else begin
         errors++;
         $display("Wrong number of writes, %0d reported where %0d were expected",
                  writeIdx, expAddr.size());
      end
   endtask

   initial begin
      reset = 1'b1;
      stall = 1'b0;
      // Straight-line ALU ops and forwarding
      runTest(1'b0, 0);
      // Branches, jumps, JAL and JR
      runTest(1'b1, 0);
      runTest(1'b1, 0);
      // Stall on about a third of cycles
      runTest(1'b1, 33);
      runTest(1'b1, 33);
      $display("Errors: %0d, writes checked: %0d", errors, checked);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // Four cycles per word plus reset and drain for every test
   initial begin
      #(numTests * (progLen * 4 + resetCycles + 8) * clkPeriod);
      $display("Timeout, the program did not reach its halt loop in time");
      $display("Errors: %0d, writes checked: %0d", errors, checked);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
+incdir+testbench
rtl/mipsPkg.sv
rtl/instrDecode.sv
rtl/regFile.sv
rtl/alu.sv
rtl/fetchUnit.sv
rtl/pipeDatapath.sv
testbench/datapathTb.sv

//--- Bender.yml
package:
  name: pipe_datapath

sources:
  - rtl/mipsPkg.sv
  - rtl/instrDecode.sv
  - rtl/regFile.sv
  - rtl/alu.sv
  - rtl/fetchUnit.sv
  - rtl/pipeDatapath.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/datapathTb.sv
